//--- Bender.yml
package:
  name: slv_guard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/slv_guard_pkg.sv
      - rtl/slv_guard_regs.sv
      - rtl/txn_budget_monitor.sv
      - rtl/slv_guard_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/axil_sub_model.sv
      - test/slv_guard_tb.sv

//--- build.f
+incdir+include
rtl/slv_guard_pkg.sv
rtl/slv_guard_regs.sv
rtl/txn_budget_monitor.sv
rtl/slv_guard_top.sv
test/axil_sub_model.sv
test/slv_guard_tb.sv

//--- include/slv_guard_settings.svh
// AXI4-Lite subordinate guard settings
// Bus widths, monitor depth, counter width and register map
`ifndef SLV_GUARD_SETTINGS_SVH
`define SLV_GUARD_SETTINGS_SVH

// Bus geometry
`define SG_ADDR_WIDTH 32
`define SG_DATA_WIDTH 32

// Open transactions tracked per direction
`define SG_MAX_OUTSTANDING 4

// Cycle counter and latency budgets
`define SG_CNT_WIDTH 16

// Register byte offsets on the configuration port
`define SG_REG_CTRL      8'h00
`define SG_REG_WR_BUDGET 8'h04
`define SG_REG_RD_BUDGET 8'h08
`define SG_REG_STATUS    8'h0C
`define SG_REG_IRQ_ADDR  8'h10

`endif

//--- rtl/slv_guard_pkg.sv
// AXI4-Lite subordinate guard types
// Channel structs, request/response bundles and register interface structs
`include "slv_guard_settings.svh"

package slv_guard_pkg;

  typedef logic [`SG_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`SG_DATA_WIDTH-1:0]   data_t;
  typedef logic [`SG_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`SG_CNT_WIDTH-1:0]    cnt_t;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t      data;
    logic [1:0] resp;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axil_rsp_t;

  // Software controlled fields
  typedef struct packed {
    logic guard_ena;
    cnt_t wr_budget;
    cnt_t rd_budget;
  } reg2hw_t;

  // Hardware updates, value is written when valid is set
  typedef struct packed {
    logic value;
    logic valid;
  } hw_bit_t;

  typedef struct packed {
    addr_t value;
    logic  valid;
  } hw_addr_t;

  typedef struct packed {
    hw_bit_t  wr_timeout;
    hw_bit_t  rd_timeout;
    hw_addr_t irq_addr;
  } hw2reg_t;

endpackage

//--- rtl/slv_guard_regs.sv
// Guard configuration and status registers
// AXI4-Lite port with enable, budgets, sticky timeout status and captured address
`timescale 1ns/1ns
`include "slv_guard_settings.svh"

module slv_guard_regs import slv_guard_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t cfg_req_i,
  output axil_rsp_t cfg_rsp_o,
  input  hw2reg_t   hw2reg_i,
  output reg2hw_t   reg2hw_o,
  output logic      irq_o
);

  logic       ena_q;
  cnt_t       wr_budget_q;
  cnt_t       rd_budget_q;
  logic       wr_stat_q;
  logic       rd_stat_q;
  addr_t      irq_addr_q;
  logic       b_valid_q;
  logic [1:0] b_resp_q;
  logic       r_valid_q;
  r_chan_t    r_q;

  logic       wr_acc;
  logic       rd_acc;
  logic [7:0] wr_off;
  logic [7:0] rd_off;
  data_t      wdata;
  strb_t      wstrb;
  logic       wr_err;
  logic [1:0] stat_clr;
  r_chan_t    r_d;

  // Byte-wise merge of a write into a register value
  function automatic data_t strb_merge(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // AW and W are only taken together
  assign wr_acc = cfg_req_i.aw_valid & cfg_req_i.w_valid & ~b_valid_q;
  assign rd_acc = cfg_req_i.ar_valid & ~r_valid_q;
  assign wr_off = cfg_req_i.aw.addr[7:0];
  assign rd_off = cfg_req_i.ar.addr[7:0];
  assign wdata  = cfg_req_i.w.data;
  assign wstrb  = cfg_req_i.w.strb;

  always_comb begin
    wr_err   = 1'b0;
    stat_clr = 2'b00;
    case (wr_off)
      `SG_REG_CTRL, `SG_REG_WR_BUDGET, `SG_REG_RD_BUDGET, `SG_REG_IRQ_ADDR: wr_err = 1'b0;
      `SG_REG_STATUS: begin
        if (wr_acc && wstrb[0]) begin
          stat_clr = wdata[1:0];
        end
      end
      default: wr_err = 1'b1;
    endcase
  end

  // Read data mux
  always_comb begin
    r_d.data = '0;
    r_d.resp = RESP_OKAY;
    case (rd_off)
      `SG_REG_CTRL:      r_d.data[0]   = ena_q;
      `SG_REG_WR_BUDGET: r_d.data      = data_t'(wr_budget_q);
      `SG_REG_RD_BUDGET: r_d.data      = data_t'(rd_budget_q);
      `SG_REG_STATUS:    r_d.data[1:0] = {rd_stat_q, wr_stat_q};
      `SG_REG_IRQ_ADDR:  r_d.data      = data_t'(irq_addr_q);
      default:           r_d.resp      = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ena_q       <= 1'b0;
      wr_budget_q <= '1;
      rd_budget_q <= '1;
      wr_stat_q   <= 1'b0;
      rd_stat_q   <= 1'b0;
      irq_addr_q  <= '0;
      b_valid_q   <= 1'b0;
      r_valid_q   <= 1'b0;
    end else begin
      if (wr_acc) begin
        case (wr_off)
          `SG_REG_CTRL: begin
            if (wstrb[0]) begin
              ena_q <= wdata[0];
            end
          end
          `SG_REG_WR_BUDGET:
            wr_budget_q <= cnt_t'(strb_merge(data_t'(wr_budget_q), wdata, wstrb));
          `SG_REG_RD_BUDGET:
            rd_budget_q <= cnt_t'(strb_merge(data_t'(rd_budget_q), wdata, wstrb));
          default: ;
        endcase
      end
      // Hardware set wins over a software clear
      if (hw2reg_i.wr_timeout.valid) begin
        wr_stat_q <= hw2reg_i.wr_timeout.value;
      end else if (stat_clr[0]) begin
        wr_stat_q <= 1'b0;
      end
      if (hw2reg_i.rd_timeout.valid) begin
        rd_stat_q <= hw2reg_i.rd_timeout.value;
      end else if (stat_clr[1]) begin
        rd_stat_q <= 1'b0;
      end
      // Only the first timeout address is kept
      if (hw2reg_i.irq_addr.valid && !wr_stat_q && !rd_stat_q) begin
        irq_addr_q <= hw2reg_i.irq_addr.value;
      end
      if (wr_acc) begin
        b_valid_q <= 1'b1;
      end else if (cfg_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (cfg_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      b_resp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_acc) begin
      r_q <= r_d;
    end
  end

  always_comb begin
    cfg_rsp_o          = '0;
    cfg_rsp_o.aw_ready = ~b_valid_q & cfg_req_i.w_valid;
    cfg_rsp_o.w_ready  = ~b_valid_q & cfg_req_i.aw_valid;
    cfg_rsp_o.b.resp   = b_resp_q;
    cfg_rsp_o.b_valid  = b_valid_q;
    cfg_rsp_o.ar_ready = ~r_valid_q;
    cfg_rsp_o.r        = r_q;
    cfg_rsp_o.r_valid  = r_valid_q;
  end

  assign reg2hw_o.guard_ena = ena_q;
  assign reg2hw_o.wr_budget = wr_budget_q;
  assign reg2hw_o.rd_budget = rd_budget_q;

  assign irq_o = wr_stat_q | rd_stat_q;

endmodule

//--- rtl/slv_guard_top.sv
// AXI4-Lite subordinate guard
// Passes traffic through, times both directions and isolates a hung subordinate
`timescale 1ns/1ns

module slv_guard_top import slv_guard_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t mgr_req_i,
  output axil_rsp_t mgr_rsp_o,
  output axil_req_t sub_req_o,
  input  axil_rsp_t sub_rsp_i,
  input  axil_req_t cfg_req_i,
  output axil_rsp_t cfg_rsp_o,
  output logic      irq_o,
  output logic      rst_req_o,
  input  logic      rst_stat_i
);

  reg2hw_t reg2hw;
  hw2reg_t hw2reg;

  logic  wr_full, rd_full;
  logic  wr_timeout, rd_timeout;
  addr_t wr_addr, rd_addr;
  logic  aw_hs, b_hs, ar_hs, r_hs;

  slv_guard_regs i_regs (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .hw2reg_i  ( hw2reg    ),
    .reg2hw_o  ( reg2hw    ),
    .irq_o     ( irq_o     )
  );

  // Handshakes seen on the subordinate side
  assign aw_hs = sub_req_o.aw_valid & sub_rsp_i.aw_ready;
  assign b_hs  = sub_rsp_i.b_valid & sub_req_o.b_ready;
  assign ar_hs = sub_req_o.ar_valid & sub_rsp_i.ar_ready;
  assign r_hs  = sub_rsp_i.r_valid & sub_req_o.r_ready;

  txn_budget_monitor #(
    .chan_t ( aw_chan_t )
  ) i_wr_monitor (
    .clk_i          ( clk_i            ),
    .rst_n_i        ( rst_n_i          ),
    .ena_i          ( reg2hw.guard_ena ),
    .budget_i       ( reg2hw.wr_budget ),
    .start_i        ( aw_hs            ),
    .chan_i         ( sub_req_o.aw     ),
    .done_i         ( b_hs             ),
    .clear_i        ( rst_stat_i       ),
    .full_o         ( wr_full          ),
    .timeout_o      ( wr_timeout       ),
    .timeout_addr_o ( wr_addr          )
  );

  txn_budget_monitor #(
    .chan_t ( ar_chan_t )
  ) i_rd_monitor (
    .clk_i          ( clk_i            ),
    .rst_n_i        ( rst_n_i          ),
    .ena_i          ( reg2hw.guard_ena ),
    .budget_i       ( reg2hw.rd_budget ),
    .start_i        ( ar_hs            ),
    .chan_i         ( sub_req_o.ar     ),
    .done_i         ( r_hs             ),
    .clear_i        ( rst_stat_i       ),
    .full_o         ( rd_full          ),
    .timeout_o      ( rd_timeout       ),
    .timeout_addr_o ( rd_addr          )
  );

  assign rst_req_o = wr_timeout | rd_timeout;

  // Write address wins when both directions time out together
  always_comb begin
    hw2reg.wr_timeout.value = 1'b1;
    hw2reg.wr_timeout.valid = wr_timeout;
    hw2reg.rd_timeout.value = 1'b1;
    hw2reg.rd_timeout.valid = rd_timeout;
    hw2reg.irq_addr.value   = wr_timeout ? wr_addr : rd_addr;
    hw2reg.irq_addr.valid   = wr_timeout | rd_timeout;
  end

  always_comb begin
    sub_req_o          = mgr_req_i;
    sub_req_o.aw_valid = mgr_req_i.aw_valid & ~wr_full;
    sub_req_o.ar_valid = mgr_req_i.ar_valid & ~rd_full;
    mgr_rsp_o          = sub_rsp_i;
    mgr_rsp_o.aw_ready = sub_rsp_i.aw_ready & ~wr_full;
    mgr_rsp_o.ar_ready = sub_rsp_i.ar_ready & ~rd_full;
    // Isolate both sides until the subordinate reset completes
    if (rst_req_o) begin
      sub_req_o = '0;
      mgr_rsp_o = '0;
    end
  end

endmodule

//--- rtl/txn_budget_monitor.sv
// Transaction latency monitor for one bus direction
// Tracks open transactions in order and flags the first one to overrun its budget
`timescale 1ns/1ns
`include "slv_guard_settings.svh"

module txn_budget_monitor import slv_guard_pkg::*; #(
  parameter type chan_t = aw_chan_t
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  ena_i,
  input  cnt_t  budget_i,
  input  logic  start_i,
  input  chan_t chan_i,
  input  logic  done_i,
  input  logic  clear_i,
  output logic  full_o,
  output logic  timeout_o,
  output addr_t timeout_addr_o
);

  localparam int unsigned Depth    = `SG_MAX_OUTSTANDING;
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrWidth-1:0]         ptr_t;
  typedef logic [$clog2(Depth+1)-1:0]  fill_t;

  // One open transaction
  typedef struct packed {
    cnt_t  stamp;
    addr_t addr;
  } entry_t;

  cnt_t   now_q;
  entry_t fifo_q [Depth];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  fill_t  fill_q;
  logic   timeout_q;
  addr_t  timeout_addr_q;

  logic   empty;
  logic   push;
  logic   pop;
  entry_t head;
  cnt_t   head_age;
  logic   late;

  function automatic ptr_t next_ptr(ptr_t ptr);
    ptr_t res;
    if (ptr == ptr_t'(Depth - 1)) begin
      res = '0;
    end else begin
      res = ptr + ptr_t'(1);
    end
    return res;
  endfunction

  assign empty  = (fill_q == '0);
  assign full_o = (fill_q == fill_t'(Depth));
  assign push   = start_i & ~full_o;
  assign pop    = done_i & ~empty;

  // Transactions complete in order, so the head is the oldest
  assign head     = fifo_q[rd_ptr_q];
  assign head_age = now_q - head.stamp;

  // Age reaches budget+1 on the coming edge
  assign late = ena_i & ~empty & (head_age >= budget_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      now_q     <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      fill_q    <= '0;
      timeout_q <= 1'b0;
    end else begin
      now_q <= now_q + cnt_t'(1);
      if (clear_i) begin
        // Subordinate was reset and has dropped everything in flight
        wr_ptr_q  <= '0;
        rd_ptr_q  <= '0;
        fill_q    <= '0;
        timeout_q <= 1'b0;
      end else begin
        if (push) begin
          wr_ptr_q <= next_ptr(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= next_ptr(rd_ptr_q);
        end
        if (push && !pop) begin
          fill_q <= fill_q + fill_t'(1);
        end else if (pop && !push) begin
          fill_q <= fill_q - fill_t'(1);
        end
        if (late) begin
          timeout_q <= 1'b1;
        end
      end
    end
  end

  // Stamp holds the counter value seen after the start edge
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{stamp: now_q + cnt_t'(1), addr: chan_i.addr};
    end
    if (late && !timeout_q && !clear_i) begin
      timeout_addr_q <= head.addr;
    end
  end

  assign timeout_o      = timeout_q;
  assign timeout_addr_o = timeout_addr_q;

endmodule

//--- test/axil_sub_model.sv
// AXI4-Lite subordinate model for the guard testbench
// Word memory with a programmable response delay per transaction
`timescale 1ns/1ns

module axil_sub_model import slv_guard_pkg::*; #(
  parameter int unsigned Words = 256
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o,
  input  cnt_t      wr_delay_i,
  input  cnt_t      rd_delay_i
);

  localparam int unsigned IdxWidth = $clog2(Words);

  data_t mem [Words];
  logic  wr_busy_q;
  logic  rd_busy_q;
  cnt_t  wr_cnt_q;
  cnt_t  rd_cnt_q;
  logic  b_valid_q;
  logic  r_valid_q;
  data_t rdata_q;
  logic  wr_acc;
  logic  rd_acc;

  // One write and one read in flight at a time
  assign wr_acc = req_i.aw_valid & req_i.w_valid & ~wr_busy_q;
  assign rd_acc = req_i.ar_valid & ~rd_busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      rd_busy_q <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      wr_cnt_q  <= '0;
      rd_cnt_q  <= '0;
    end else begin
      if (wr_acc) begin
        wr_busy_q <= 1'b1;
        wr_cnt_q  <= wr_delay_i;
      end else if (wr_busy_q && !b_valid_q) begin
        if (wr_cnt_q == '0) begin
          b_valid_q <= 1'b1;
        end else begin
          wr_cnt_q <= wr_cnt_q - cnt_t'(1);
        end
      end else if (b_valid_q && req_i.b_ready) begin
        b_valid_q <= 1'b0;
        wr_busy_q <= 1'b0;
      end
      if (rd_acc) begin
        rd_busy_q <= 1'b1;
        rd_cnt_q  <= rd_delay_i;
        rdata_q   <= mem[req_i.ar.addr[2 +: IdxWidth]];
      end else if (rd_busy_q && !r_valid_q) begin
        if (rd_cnt_q == '0) begin
          r_valid_q <= 1'b1;
        end else begin
          rd_cnt_q <= rd_cnt_q - cnt_t'(1);
        end
      end else if (r_valid_q && req_i.r_ready) begin
        r_valid_q <= 1'b0;
        rd_busy_q <= 1'b0;
      end
    end
  end

  // Memory contents survive a subordinate reset
  always_ff @(posedge clk_i) begin
    if (rst_n_i && wr_acc) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (req_i.w.strb[i]) begin
          mem[req_i.aw.addr[2 +: IdxWidth]][i*8 +: 8] <= req_i.w.data[i*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = req_i.aw_valid & req_i.w_valid & ~wr_busy_q;
    rsp_o.w_ready  = req_i.aw_valid & req_i.w_valid & ~wr_busy_q;
    rsp_o.b.resp   = RESP_OKAY;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.ar_ready = ~rd_busy_q;
    rsp_o.r.data   = rdata_q;
    rsp_o.r.resp   = RESP_OKAY;
    rsp_o.r_valid  = r_valid_q;
  end

endmodule

//--- test/slv_guard_tb.sv
// Testbench for the AXI4-Lite subordinate guard
// Random traffic, write and read timeouts, cut-off and recovery
`timescale 1ns/1ns
`include "slv_guard_settings.svh"

module slv_guard_tb import slv_guard_pkg::*; ();

  localparam int unsigned BUDGET      = 20;
  localparam int unsigned NUM_PASS    = 40;
  localparam int unsigned TXN_COUNT   = 120;
  localparam int unsigned SLOW_MAX    = BUDGET + 12;
  localparam int unsigned CYCLE_LIMIT = TXN_COUNT * 64 + 2 * NUM_PASS * (BUDGET - 3)
                                        + 3 * SLOW_MAX;
  localparam addr_t       BASE        = 32'h4000_0000;

  logic      clk;
  logic      rst_n;
  logic      sub_rst_n;
  logic      rst_stat;
  logic      irq;
  logic      rst_req;
  axil_req_t mgr_req;
  axil_rsp_t mgr_rsp;
  axil_req_t sub_req;
  axil_rsp_t sub_rsp;
  axil_req_t cfg_req;
  axil_rsp_t cfg_rsp;
  cnt_t      wr_delay;
  cnt_t      rd_delay;

  logic [31:0] rng;
  data_t       ref_mem [256];
  addr_t       addr_list [NUM_PASS];
  string       test_name;
  int          test_errs;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          cycles = 0;
  logic        quiet_on;
  logic        quiet_viol;

  slv_guard_top uut (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .mgr_req_i  ( mgr_req  ),
    .mgr_rsp_o  ( mgr_rsp  ),
    .sub_req_o  ( sub_req  ),
    .sub_rsp_i  ( sub_rsp  ),
    .cfg_req_i  ( cfg_req  ),
    .cfg_rsp_o  ( cfg_rsp  ),
    .irq_o      ( irq      ),
    .rst_req_o  ( rst_req  ),
    .rst_stat_i ( rst_stat )
  );

  axil_sub_model i_sub (
    .clk_i      ( clk                ),
    .rst_n_i    ( rst_n && sub_rst_n ),
    .req_i      ( sub_req            ),
    .rsp_o      ( sub_rsp            ),
    .wr_delay_i ( wr_delay           ),
    .rd_delay_i ( rd_delay           )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("test failed");
      $finish;
    end
  end

  // Watch for spurious timeouts during normal traffic
  always @(negedge clk) begin
    if (quiet_on && (irq || rst_req)) begin
      quiet_viol = 1'b1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] val);
    rng = xorshift32(rng);
    val = rng;
  endtask

  task automatic flag_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic note_error(input string msg);
    $display("ERROR %s %s", test_name, msg);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("PASS %s", test_name);
    end else begin
      $display("DONE %s with %0d errors", test_name, test_errs);
      tests_failed++;
      err_cnt += test_errs;
    end
  endtask

  // AW and W go out together on the config port, B and R ready stay high
  task automatic cfg_write_resp(input logic [7:0] off, input data_t data,
                                output logic [1:0] resp);
    @(negedge clk);
    cfg_req.aw.addr = addr_t'(off);
    cfg_req.aw_valid = 1'b1;
    cfg_req.w.data = data;
    cfg_req.w.strb = '1;
    cfg_req.w_valid = 1'b1;
    #1;
    while (!(cfg_rsp.aw_ready && cfg_rsp.w_ready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cfg_req.aw_valid = 1'b0;
    cfg_req.w_valid = 1'b0;
    #1;
    while (!cfg_rsp.b_valid) begin
      @(negedge clk);
      #1;
    end
    resp = cfg_rsp.b.resp;
    @(negedge clk);
  endtask

  task automatic cfg_write(input logic [7:0] off, input data_t data);
    logic [1:0] resp;
    cfg_write_resp(off, data, resp);
    if (resp !== RESP_OKAY) begin
      flag_mismatch("config write response", RESP_OKAY, resp);
    end
  endtask

  task automatic cfg_read(input logic [7:0] off, output data_t data, output logic [1:0] resp);
    @(negedge clk);
    cfg_req.ar.addr = addr_t'(off);
    cfg_req.ar_valid = 1'b1;
    #1;
    while (!cfg_rsp.ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cfg_req.ar_valid = 1'b0;
    #1;
    while (!cfg_rsp.r_valid) begin
      @(negedge clk);
      #1;
    end
    data = cfg_rsp.r.data;
    resp = cfg_rsp.r.resp;
    @(negedge clk);
  endtask

  task automatic expect_reg(input logic [7:0] off, input data_t exp, input string what);
    data_t      data;
    logic [1:0] resp;
    cfg_read(off, data, resp);
    if (data !== exp) begin
      flag_mismatch(what, exp, data);
    end
  endtask

  task automatic drive_write(input addr_t addr, input data_t data);
    @(negedge clk);
    mgr_req.aw.addr = addr;
    mgr_req.aw_valid = 1'b1;
    mgr_req.w.data = data;
    mgr_req.w.strb = '1;
    mgr_req.w_valid = 1'b1;
  endtask

  // Returns on the falling edge after the AW and W handshake
  task automatic wait_write_addr();
    #1;
    while (!(mgr_rsp.aw_ready && mgr_rsp.w_ready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    mgr_req.aw_valid = 1'b0;
    mgr_req.w_valid = 1'b0;
  endtask

  task automatic wait_write_resp(output logic [1:0] resp);
    #1;
    while (!mgr_rsp.b_valid) begin
      @(negedge clk);
      #1;
    end
    resp = mgr_rsp.b.resp;
    @(negedge clk);
  endtask

  task automatic drive_read(input addr_t addr);
    @(negedge clk);
    mgr_req.ar.addr = addr;
    mgr_req.ar_valid = 1'b1;
  endtask

  task automatic wait_read_addr();
    #1;
    while (!mgr_rsp.ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    mgr_req.ar_valid = 1'b0;
  endtask

  task automatic wait_read_resp(output data_t data, output logic [1:0] resp);
    #1;
    while (!mgr_rsp.r_valid) begin
      @(negedge clk);
      #1;
    end
    data = mgr_rsp.r.data;
    resp = mgr_rsp.r.resp;
    @(negedge clk);
  endtask

  task automatic mgr_write(input addr_t addr, input data_t data, output logic [1:0] resp);
    drive_write(addr, data);
    wait_write_addr();
    wait_write_resp(resp);
  endtask

  task automatic mgr_read(input addr_t addr, output data_t data, output logic [1:0] resp);
    drive_read(addr);
    wait_read_addr();
    wait_read_resp(data, resp);
  endtask

  // Called on the first falling edge after the start handshake
  task automatic wait_rst_req(output int edges);
    edges = 0;
    #1;
    while (!rst_req) begin
      @(negedge clk);
      #1;
      edges++;
    end
    @(negedge clk);
  endtask

  // Subordinate reset, then the reset-done pulse to the guard
  task automatic recover();
    @(negedge clk);
    sub_rst_n = 1'b0;
    @(negedge clk);
    sub_rst_n = 1'b1;
    rst_stat = 1'b1;
    #1;
    if (!rst_req) begin
      note_error("rst_req_o dropped before the reset done pulse");
    end
    @(negedge clk);
    rst_stat = 1'b0;
    #1;
    if (rst_req) begin
      note_error("rst_req_o still high one edge after the reset done pulse");
    end
    @(negedge clk);
  endtask

  task automatic clear_status();
    cfg_write(`SG_REG_STATUS, 32'h3);
    if (irq !== 1'b0) begin
      flag_mismatch("irq_o after status clear", 32'h0, irq);
    end
    expect_reg(`SG_REG_STATUS, 32'h0, "status after clear");
  endtask

  initial begin
    logic [31:0] r;
    data_t       rdata;
    data_t       wdata;
    data_t       hdata;
    addr_t       taddr;
    addr_t       haddr;
    logic [1:0]  resp;
    logic [1:0]  rresp;
    int          k;
    rng = 32'd26339;
    mgr_req = '0;
    mgr_req.b_ready = 1'b1;
    mgr_req.r_ready = 1'b1;
    cfg_req = '0;
    cfg_req.b_ready = 1'b1;
    cfg_req.r_ready = 1'b1;
    rst_stat = 1'b0;
    sub_rst_n = 1'b1;
    wr_delay = '0;
    rd_delay = '0;
    quiet_on = 1'b0;
    quiet_viol = 1'b0;
    test_errs = 0;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    begin_test("register_access");
    if (irq !== 1'b0 || rst_req !== 1'b0 || cfg_rsp.b_valid !== 1'b0 ||
        cfg_rsp.r_valid !== 1'b0) begin
      note_error("an output was not low right after reset");
    end
    expect_reg(`SG_REG_CTRL, 32'h0, "ctrl reset value");
    expect_reg(`SG_REG_WR_BUDGET, 32'h0000_FFFF, "write budget reset value");
    expect_reg(`SG_REG_RD_BUDGET, 32'h0000_FFFF, "read budget reset value");
    expect_reg(`SG_REG_STATUS, 32'h0, "status reset value");
    draw(r);
    cfg_write(`SG_REG_WR_BUDGET, {16'h0, r[15:0]});
    expect_reg(`SG_REG_WR_BUDGET, {16'h0, r[15:0]}, "write budget readback");
    draw(r);
    cfg_write(`SG_REG_RD_BUDGET, {16'h0, r[15:0]});
    expect_reg(`SG_REG_RD_BUDGET, {16'h0, r[15:0]}, "read budget readback");
    cfg_write(`SG_REG_WR_BUDGET, BUDGET);
    cfg_write(`SG_REG_RD_BUDGET, BUDGET);
    cfg_write(`SG_REG_CTRL, 32'h1);
    expect_reg(`SG_REG_CTRL, 32'h1, "ctrl readback");
    expect_reg(`SG_REG_WR_BUDGET, BUDGET, "write budget final");
    expect_reg(`SG_REG_RD_BUDGET, BUDGET, "read budget final");
    cfg_read(8'h14, rdata, resp);
    if (resp !== RESP_SLVERR) begin
      flag_mismatch("unmapped offset response", RESP_SLVERR, resp);
    end
    cfg_write_resp(8'h14, 32'hFFFF_FFFF, resp);
    if (resp !== RESP_SLVERR) begin
      flag_mismatch("unmapped offset write response", RESP_SLVERR, resp);
    end
    end_test();

    begin_test("pass_through");
    quiet_viol = 1'b0;
    quiet_on = 1'b1;
    for (int i = 0; i < NUM_PASS; i++) begin
      draw(r);
      addr_list[i] = BASE | (r & 32'h3FC);
      draw(wdata);
      draw(r);
      wr_delay = cnt_t'(r % (BUDGET - 2));
      mgr_write(addr_list[i], wdata, resp);
      ref_mem[addr_list[i][9:2]] = wdata;
      if (resp !== RESP_OKAY) begin
        flag_mismatch("write response", RESP_OKAY, resp);
      end
    end
    for (int i = 0; i < NUM_PASS; i++) begin
      draw(r);
      rd_delay = cnt_t'(r % (BUDGET - 2));
      mgr_read(addr_list[i], rdata, resp);
      if (rdata !== ref_mem[addr_list[i][9:2]]) begin
        flag_mismatch("read data", ref_mem[addr_list[i][9:2]], rdata);
      end
      if (resp !== RESP_OKAY) begin
        flag_mismatch("read response", RESP_OKAY, resp);
      end
    end
    quiet_on = 1'b0;
    if (quiet_viol) begin
      note_error("irq_o or rst_req_o went high during normal traffic");
    end
    end_test();

    begin_test("write_timeout");
    draw(r);
    taddr = BASE | (r & 32'h3FC);
    draw(wdata);
    draw(r);
    wr_delay = cnt_t'(BUDGET + 5 + (r % 8));
    drive_write(taddr, wdata);
    wait_write_addr();
    ref_mem[taddr[9:2]] = wdata;
    wait_rst_req(k);
    if (k != BUDGET + 1) begin
      flag_mismatch("edges from AW to timeout", BUDGET + 1, k);
    end
    if (irq !== 1'b1) begin
      flag_mismatch("irq_o", 32'h1, irq);
    end
    expect_reg(`SG_REG_STATUS, 32'h1, "status");
    expect_reg(`SG_REG_IRQ_ADDR, taddr, "irq address");
    end_test();

    begin_test("cutoff_recovery");
    draw(hdata);
    haddr = addr_list[0] ^ 32'h4;
    wr_delay = cnt_t'(2);
    rd_delay = cnt_t'(2);
    drive_write(haddr, hdata);
    mgr_req.ar.addr = addr_list[0];
    mgr_req.ar_valid = 1'b1;
    for (int c = 0; c < 8; c++) begin
      #1;
      if (mgr_rsp.aw_ready || mgr_rsp.w_ready || mgr_rsp.ar_ready) begin
        note_error("manager saw a ready during the cut-off");
      end
      if (sub_req.aw_valid || sub_req.w_valid || sub_req.ar_valid) begin
        note_error("a request reached the subordinate during the cut-off");
      end
      @(negedge clk);
    end
    // Held requests go through once the cut-off lifts
    fork
      recover();
      wait_write_addr();
      wait_read_addr();
    join
    fork
      wait_write_resp(resp);
      wait_read_resp(rdata, rresp);
    join
    ref_mem[haddr[9:2]] = hdata;
    if (rdata !== ref_mem[addr_list[0][9:2]]) begin
      flag_mismatch("held read data", ref_mem[addr_list[0][9:2]], rdata);
    end
    clear_status();
    mgr_read(haddr, rdata, rresp);
    if (rdata !== hdata) begin
      flag_mismatch("read after recovery", hdata, rdata);
    end
    end_test();

    begin_test("read_timeout_enable");
    cfg_write(`SG_REG_CTRL, 32'h0);
    draw(r);
    rd_delay = cnt_t'(BUDGET + 8 + (r % 4));
    quiet_viol = 1'b0;
    quiet_on = 1'b1;
    mgr_read(haddr, rdata, rresp);
    quiet_on = 1'b0;
    if (quiet_viol) begin
      note_error("timeout flagged while the guard was disabled");
    end
    if (rdata !== hdata) begin
      flag_mismatch("slow read data", hdata, rdata);
    end
    expect_reg(`SG_REG_STATUS, 32'h0, "status while disabled");
    cfg_write(`SG_REG_CTRL, 32'h1);
    drive_read(haddr);
    wait_read_addr();
    wait_rst_req(k);
    if (k != BUDGET + 1) begin
      flag_mismatch("edges from AR to timeout", BUDGET + 1, k);
    end
    if (irq !== 1'b1) begin
      flag_mismatch("irq_o", 32'h1, irq);
    end
    expect_reg(`SG_REG_STATUS, 32'h2, "status");
    expect_reg(`SG_REG_IRQ_ADDR, haddr, "irq address");
    recover();
    clear_status();
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
